/* testbench/wb_stimulus.txt */
# op addr wdata expect, hex fields; op W write, R read, B both request bits, N no request
# expect is checked on R and B lines only
W 00000010 11111111 00000000
W 00000024 a5a5c3c3 00000000
W 000003fc deadbeef 00000000
R 00000010 00000000 11111111
R 000003fc 00000000 deadbeef
R 00400024 00000000 a5a5c3c3
W 00400010 22222222 00000000
R 00000010 00000000 22222222
R 20030000 00000000 57420001
W 20000000 0000aaaa 00000000
W 20010000 0000bbbb 00000000
W 20020000 0000cccc 00000000
W 20010000 12345678 00000000
R 20000000 00000000 0000aaaa
R 20020000 00000000 0000cccc
R 20010000 00000000 12345678
W 20030000 ffffffff 00000000
R 20030000 00000000 57420001
N 00000010 99999999 00000000
B 00000010 77777777 22222222
R 00000010 00000000 22222222
W 20000024 0badf00d 00000000
R 00000024 00000000 a5a5c3c3
W 00000000 13579bdf 00000000
R 20000000 00000000 0badf00d

/* flist.f */
hdl/wb_pkg.sv
hdl/wb_master.sv
hdl/wb_decoder.sv
hdl/wb_data_ram.sv
hdl/wb_dev_regs.sv
hdl/wb_subsystem.sv
testbench/wb_chk.sv
testbench/wb_tb.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = wb_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SRCS      = $(shell cat $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/wb_tb.sv */
// testbench for wb_subsystem: replays the stimulus file and checks reads against a bus model
`timescale 1ns/1ps

module wb_tb import wb_pkg::*; ();

    logic      clk_i;
    logic      rst_i;
    wb_addr_t  cmd_addr_i;
    cmd_word_t cmd_word_i;
    logic      cmd_busy_o;
    wb_data_t  cmd_rdata_o;

    // stimulus table, one entry per command line
    logic [7:0] op_q [$];
    wb_addr_t   addr_q [$];
    wb_data_t   wdata_q [$];
    wb_data_t   exp_q [$];
    int         n_cmds = 0;

    // reference model of memory and device registers
    wb_data_t mem_model [RAM_DEPTH];
    bit       mem_written [RAM_DEPTH];
    wb_data_t dev_model [NUM_DEV_REGS] = '{default: '0};

    wb_subsystem u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_word_i  (cmd_word_i),
        .cmd_busy_o  (cmd_busy_o),
        .cmd_rdata_o (cmd_rdata_o)
    );

    initial clk_i = 1'b0;
    always #5 clk_i = !clk_i;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run aborted");
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic load_stimulus();
        int         fd;
        string      line;
        logic [7:0] op;
        wb_addr_t   a;
        wb_data_t   wd;
        wb_data_t   ex;
        fd = $fopen("testbench/wb_stimulus.txt", "r");
        if (fd == 0) fail_run("cannot open testbench/wb_stimulus.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 3 && line[0] != "#") begin
                if ($sscanf(line, "%c %h %h %h", op, a, wd, ex) != 4)
                    fail_run({"badly formed stimulus line: ", line});
                op_q.push_back(op);
                addr_q.push_back(a);
                wdata_q.push_back(wd);
                exp_q.push_back(ex);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) fail_run("stimulus file holds no commands");
        n_cmds = op_q.size();
    endtask

    task automatic run_cmd(input logic [7:0] op, input wb_addr_t addr, input wb_data_t wdata,
                           input wb_data_t exp_data);
        logic [1:0]           req_bits;
        int                   waited;
        logic                 dev;
        wb_sel_t              dev_idx;
        logic [RAM_IDX_W-1:0] widx;
        wb_data_t             model_data;
        case (op)
            "W":     req_bits = 2'b10;
            "R":     req_bits = 2'b01;
            "B":     req_bits = 2'b11;   // both bits set, must act as a read
            "N":     req_bits = 2'b00;
            default: fail_run("unknown operation in stimulus file");
        endcase
        dev     = addr[DEV_REGION_BIT];
        dev_idx = addr[DEV_SEL_LSB +: 2];
        widx    = addr[RAM_IDX_LSB +: RAM_IDX_W];
        cmd_addr_i = addr;
        cmd_word_i = {req_bits, wdata};
        if (op == "N") begin
            repeat (3) begin
                next_cycle();
                check_equal(32'(cmd_busy_o), 32'd0, "busy after empty command");
            end
            cmd_word_i = '0;
        end else begin
            waited = 0;
            do begin
                next_cycle();
                waited++;
            end while (!cmd_busy_o && waited < 10);
            if (!cmd_busy_o) fail_run("busy never rose after a request");
            cmd_word_i = '0;        // drop request while busy
            while (cmd_busy_o && waited < 10) begin
                next_cycle();
                waited++;
            end
            if (cmd_busy_o) fail_run("busy stayed high for more than 10 cycles");
            if (op == "W") begin
                if (!dev) begin
                    mem_model[widx]   = wdata;
                    mem_written[widx] = 1'b1;
                end else if (dev_idx != 2'd3) begin
                    dev_model[dev_idx] = wdata;
                end
            end else begin
                if (dev) begin
                    model_data = (dev_idx == 2'd3) ? 32'h5742_0001 : dev_model[dev_idx];
                end else begin
                    if (!mem_written[widx]) fail_run("stimulus reads a memory word never written");
                    model_data = mem_model[widx];
                end
                check_equal(exp_data, model_data, "stimulus expectation against model");
                check_equal(cmd_rdata_o, exp_data, "read data");
            end
        end
    endtask

    initial begin : watchdog
        wait (n_cmds > 0);
        repeat (16 + 4 + 10 * n_cmds) @(posedge clk_i);
        $display("timeout: the DUT did not finish %0d commands in time", n_cmds);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        rst_i      = 1'b0;
        cmd_addr_i = '0;
        cmd_word_i = '0;
        void'($urandom(32'hb0bc_e84d));
        load_stimulus();
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        check_equal(32'(cmd_busy_o), 32'd0, "busy after reset");
        check_equal(cmd_rdata_o, 32'd0, "read data after reset");
        for (int i = 0; i < n_cmds; i++) begin
            repeat ($urandom % 4) next_cycle();   // random idle gap
            run_cmd(op_q[i], addr_q[i], wdata_q[i], exp_q[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* testbench/wb_chk.sv */
// wishbone protocol assertions, bound into the master of the bus subsystem
`timescale 1ns/1ps

module wb_chk import wb_pkg::*; (
    input logic    clk_i,
    input logic    rst_i,
    input logic    busy_i,
    input wb_req_t req_i,
    input wb_rsp_t rsp_i
);

    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_i.stb |-> req_i.cyc)
        else $error("stb high outside a bus cycle");

    // payload held until the slave answers
    fields_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
        req_i.stb && !rsp_i.ack |=> $stable({req_i.addr, req_i.wdata, req_i.sel, req_i.we}))
        else $error("request fields changed while waiting for ack");

    ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_i)
        rsp_i.ack |-> req_i.stb)
        else $error("ack without a strobe");

    busy_drops_after_ack: assert property (@(posedge clk_i) disable iff (!rst_i)
        rsp_i.ack |-> busy_i ##1 !busy_i)  // ack edge ends the command
        else $error("busy did not fall exactly one cycle after ack");

endmodule

bind wb_master wb_chk u_chk (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .busy_i (cmd_busy_o),
    .req_i  (bus_req_o),
    .rsp_i  (bus_rsp_i)
);

/* hdl/wb_subsystem.sv */
// top level of the bus subsystem: master, decoder, data memory and device block
`timescale 1ns/1ps

module wb_subsystem import wb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  wb_addr_t  cmd_addr_i,
    input  cmd_word_t cmd_word_i,
    output logic      cmd_busy_o,
    output wb_data_t  cmd_rdata_o
);

    wb_req_t bus_req;
    wb_req_t mem_req;
    wb_req_t dev_req;
    wb_rsp_t bus_rsp;
    wb_rsp_t mem_rsp;
    wb_rsp_t dev_rsp;

    wb_master u_master (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_word_i  (cmd_word_i),
        .cmd_busy_o  (cmd_busy_o),
        .cmd_rdata_o (cmd_rdata_o),
        .bus_req_o   (bus_req),
        .bus_rsp_i   (bus_rsp)
    );

    wb_decoder u_decoder (
        .bus_req_i (bus_req),
        .mem_req_o (mem_req),
        .dev_req_o (dev_req),
        .mem_rsp_i (mem_rsp),
        .dev_rsp_i (dev_rsp),
        .bus_rsp_o (bus_rsp)
    );

    wb_data_ram u_ram (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (mem_req),
        .rsp_o (mem_rsp)
    );

    wb_dev_regs u_dev (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (dev_req),
        .rsp_o (dev_rsp)
    );

endmodule

/* hdl/wb_dev_regs.sv */
// device slave: three r/w registers plus a read-only id word, two wait states per cycle
`timescale 1ns/1ps

module wb_dev_regs import wb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    wb_data_t regs_q [NUM_DEV_REGS];

    logic     active;
    logic     wait_q;     // first wait state seen
    logic     ack_q;
    wb_data_t rd_word;
    wb_data_t rdata_q;

    assign active = req_i.cyc && req_i.stb && !ack_q;

    // sel carries the device index
    always_comb begin
        case (req_i.sel)
            2'd0:    rd_word = regs_q[0];
            2'd1:    rd_word = regs_q[1];
            2'd2:    rd_word = regs_q[2];
            default: rd_word = DEV_ID_VALUE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wait_q <= 1'b0;
            ack_q  <= 1'b0;
            regs_q <= '{default: '0};
        end else begin
            wait_q <= 1'b0;
            ack_q  <= 1'b0;
            if (active) begin
                if (wait_q) begin
                    ack_q <= 1'b1;
                    if (req_i.we && req_i.sel != DEV_ID_IDX) begin
                        regs_q[req_i.sel] <= req_i.wdata;
                    end
                end else begin
                    wait_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (active && wait_q) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = ack_q;

endmodule

/* hdl/wb_data_ram.sv */
// data memory slave, 256 words, answers every cycle after one wait state
`timescale 1ns/1ps

module wb_data_ram import wb_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    wb_data_t mem [RAM_DEPTH];

    logic [RAM_IDX_W-1:0] idx;
    logic                 access;
    logic                 wait_done_q;  // one-cycle wait counter, doubles as ack
    wb_data_t             rdata_q;

    assign idx    = req_i.addr[RAM_IDX_LSB +: RAM_IDX_W];
    assign access = req_i.cyc && req_i.stb && !wait_done_q;

    // ack for exactly one cycle, master drops stb on the same edge it sees it
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wait_done_q <= 1'b0;
        end else begin
            wait_done_q <= access;
        end
    end

    // array and read data move on the edge that raises ack
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (req_i.we) begin
                mem[idx] <= req_i.wdata;
            end
            rdata_q <= mem[idx];   // old word on writes, master ignores it
        end
    end

    assign rsp_o.rdata = rdata_q;
    assign rsp_o.ack   = wait_done_q;

endmodule

/* hdl/wb_decoder.sv */
// address decoder: steers the master's cycle to memory or devices and muxes the response back
`timescale 1ns/1ps

module wb_decoder import wb_pkg::*; (
    input  wb_req_t bus_req_i,

    output wb_req_t mem_req_o,
    output wb_req_t dev_req_o,

    input  wb_rsp_t mem_rsp_i,
    input  wb_rsp_t dev_rsp_i,
    output wb_rsp_t bus_rsp_o
);

    logic dev_hit;

    // region bit only, device index is decoded in the device block
    assign dev_hit = bus_req_i.addr[DEV_REGION_BIT];

    always_comb begin
        // payload goes to both slaves
        mem_req_o = bus_req_i;
        dev_req_o = bus_req_i;

        // qualifiers only reach the addressed slave
        mem_req_o.cyc = bus_req_i.cyc && !dev_hit;
        mem_req_o.stb = bus_req_i.stb && !dev_hit;
        dev_req_o.cyc = bus_req_i.cyc && dev_hit;
        dev_req_o.stb = bus_req_i.stb && dev_hit;
    end

    assign bus_rsp_o = dev_hit ? dev_rsp_i : mem_rsp_i;

endmodule

/* hdl/wb_master.sv */
// wishbone classic master: takes held cpu commands and runs one bus cycle per command
`timescale 1ns/1ps

module wb_master import wb_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,

    // cpu side
    input  wb_addr_t  cmd_addr_i,
    input  cmd_word_t cmd_word_i,
    output logic      cmd_busy_o,
    output wb_data_t  cmd_rdata_o,

    // bus side
    output wb_req_t   bus_req_o,
    input  wb_rsp_t   bus_rsp_i
);

    master_state_t state_q;
    wb_req_t       req_q;
    wb_data_t      rdata_q;

    logic    rd_req;
    logic    wr_req;
    wb_sel_t sel_n;

    assign rd_req = cmd_word_i[CMD_RD_BIT];
    assign wr_req = cmd_word_i[CMD_WR_BIT];

    // devices get their index on sel, memory gets all lanes
    assign sel_n = cmd_addr_i[DEV_REGION_BIT] ? cmd_addr_i[DEV_SEL_LSB +: WB_SEL_W]
                                              : SEL_MEM;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            req_q   <= '0;
            rdata_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (rd_req || wr_req) begin
                        req_q.addr  <= cmd_addr_i;
                        req_q.wdata <= rd_req ? '0 : cmd_word_i[WB_DATA_W-1:0];
                        req_q.sel   <= sel_n;
                        req_q.we    <= !rd_req;  // read wins when both set
                        req_q.cyc   <= 1'b1;
                        req_q.stb   <= 1'b1;
                        state_q     <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (bus_rsp_i.ack) begin
                        if (!req_q.we) begin
                            rdata_q <= bus_rsp_i.rdata;
                        end
                        req_q   <= '0;     // drop cyc/stb on the ack edge
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign cmd_busy_o  = (state_q == WAIT_ACK);
    assign cmd_rdata_o = rdata_q;
    assign bus_req_o   = req_q;

endmodule

/* hdl/wb_pkg.sv */
// widths, bus structs, address map and master states shared by every wishbone block
package wb_pkg;

    localparam int WB_ADDR_W = 32;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 2;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;
    typedef logic [33:0]          cmd_word_t;   // [33] write, [32] read, [31:0] data

    localparam int CMD_WR_BIT = 33;
    localparam int CMD_RD_BIT = 32;

    // 69-bit request driven by the master
    typedef struct packed {
        wb_addr_t addr;
        wb_data_t wdata;
        wb_sel_t  sel;
        logic     we;
        logic     cyc;
        logic     stb;
    } wb_req_t;

    // 33-bit response from a slave
    typedef struct packed {
        wb_data_t rdata;
        logic     ack;
    } wb_rsp_t;

    // address map
    localparam int      DEV_REGION_BIT = 29;  // set selects the device block
    localparam int      DEV_SEL_LSB    = 16;  // device index in addr[17:16]
    localparam wb_sel_t SEL_MEM        = '1;

    localparam int RAM_DEPTH   = 256;
    localparam int RAM_IDX_LSB = 2;
    localparam int RAM_IDX_W   = $clog2(RAM_DEPTH);

    localparam int       NUM_DEV_REGS = 3;
    localparam wb_sel_t  DEV_ID_IDX   = 2'd3; // read-only id slot
    localparam wb_data_t DEV_ID_VALUE = 32'h5742_0001;

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } master_state_t;

endpackage
